// File: Bender.yml
package:
  name: narrow_link

sources:
  # design sources in compile order
  - files:
      - common/narrow_pkg.sv
      - common/lane_if.sv
      - logic/word_dispatcher.sv
      - channel_narrow/narrow_lane.sv
      - logic/piece_collector.sv
      - logic/narrow_link_top.sv

  # testbench, checker and bound assertions
  - target: test
    files:
      - verif/narrow_link_asserts.sv
      - verif/narrow_link_checker.sv
      - verif/narrow_link_tb.sv

// File: build.f
common/narrow_pkg.sv
common/lane_if.sv
logic/word_dispatcher.sv
channel_narrow/narrow_lane.sv
logic/piece_collector.sv
logic/narrow_link_top.sv
verif/narrow_link_asserts.sv
verif/narrow_link_checker.sv
verif/narrow_link_tb.sv

// File: channel_narrow/narrow_lane.sv
`timescale 1ns/10ps

// holds one wide word and hands it out one piece at a time starting at the LSB
// the last piece carries the leftover bits with zeros above them
module narrow_lane (
  input  logic clk_i,
  input  logic reset_i,
  lane_if.lane lane
);

  logic [narrow_pkg::WORD_WIDTH-1:0]      word_r;
  logic                                   valid_r;
  logic [narrow_pkg::PIECE_CNT_WIDTH-1:0] count_r;
  logic [narrow_pkg::PIECE_CNT_WIDTH-1:0] count_n;
  logic                                   last_piece;
  logic [narrow_pkg::PIECE_WIDTH-1:0]     pieces [narrow_pkg::NUM_PIECES];

  // full-width slices for all pieces except the last
  for (genvar i = 0; i < narrow_pkg::NUM_PIECES - 1; i++) begin : g_slice
    assign pieces[i] = word_r[narrow_pkg::PIECE_WIDTH*i +: narrow_pkg::PIECE_WIDTH];
  end

  // the last piece is padded with zeros in its top bits
  assign pieces[narrow_pkg::NUM_PIECES-1] = {
    {narrow_pkg::PAD_WIDTH{1'b0}},
    word_r[narrow_pkg::WORD_WIDTH-1 : narrow_pkg::PIECE_WIDTH*(narrow_pkg::NUM_PIECES-1)]
  };

  assign last_piece =
      (count_r == narrow_pkg::PIECE_CNT_WIDTH'(narrow_pkg::NUM_PIECES - 1));

  // the counter only moves on a dequeue and goes back to zero after the last piece
  always_comb begin
    count_n = count_r;
    if (lane.piece_deque) begin
      if (last_piece) begin
        count_n = '0;
      end else begin
        count_n = count_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_r <= '0;
    end else begin
      count_r <= count_n;
    end
  end

  // word storage is written only on a load strobe
  always_ff @(posedge clk_i) begin
    if (lane.word_valid) begin
      word_r <= lane.word_data;
    end
  end

  // valid goes up the cycle after a load and falls on the edge after release
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r <= 1'b0;
    end else if (lane.word_valid) begin
      valid_r <= 1'b1;
    end else if (lane.word_release) begin
      valid_r <= 1'b0;
    end
  end

  assign lane.piece_valid = valid_r;

  // piece mux follows the counter
  assign lane.piece_data  = pieces[count_r];

  // release in the same cycle as the last dequeue
  assign lane.word_release = lane.piece_deque && last_piece;

endmodule

// File: common/lane_if.sv
`timescale 1ns/10ps

// one lane's connection between the dispatcher, the lane itself and the collector
interface lane_if;

  // the dispatcher drives the load strobe and the word it carries
  logic                                 word_valid;
  logic [narrow_pkg::WORD_WIDTH-1:0]    word_data;

  // pulses with the dequeue of the last piece, so the lane can be refilled
  logic                                 word_release;

  // current piece of the held word
  logic                                 piece_valid;
  logic [narrow_pkg::PIECE_WIDTH-1:0]   piece_data;

  // the collector takes the current piece
  logic                                 piece_deque;

  // dispatcher side
  modport feed (
    output word_valid,
    output word_data,
    input  word_release
  );

  // the narrowing lane
  modport lane (
    input  word_valid,
    input  word_data,
    input  piece_deque,
    output word_release,
    output piece_valid,
    output piece_data
  );

  // the collector also watches release to know when to move on
  modport drain (
    input  piece_valid,
    input  piece_data,
    input  word_release,
    output piece_deque
  );

endinterface

// File: common/narrow_pkg.sv
// shared widths, counts and state encodings for the four-lane narrowing link
// every module refers to these by scoped name
package narrow_pkg;

  // an input word is 28 bits wide
  localparam int unsigned WORD_WIDTH = 28;

  // each output piece is one byte
  localparam int unsigned PIECE_WIDTH = 8;

  // pieces per word are rounded up so the leftover bits get a piece of their own
  localparam int unsigned NUM_PIECES = (WORD_WIDTH + PIECE_WIDTH - 1) / PIECE_WIDTH;

  // zero bits that fill the top of the last piece
  localparam int unsigned PAD_WIDTH = NUM_PIECES * PIECE_WIDTH - WORD_WIDTH;

  // number of narrowing lanes that words are dealt to
  localparam int unsigned NUM_LANES = 4;

  // width of a lane pointer in the dispatcher and the collector
  localparam int unsigned LANE_SEL_WIDTH = $clog2(NUM_LANES);

  // width of the piece counter inside each lane
  localparam int unsigned PIECE_CNT_WIDTH = $clog2(NUM_PIECES);

  // phases of the output four-phase handshake in the collector
  typedef enum logic [1:0] {
    hs_idle,
    hs_wait_ack_high,
    hs_wait_ack_low
  } hs_state_e;

  // phases of the input four-phase handshake in the dispatcher
  // in_ack_high means ack is up and we wait for the source to drop req
  typedef enum logic {
    in_idle,
    in_ack_high
  } in_state_e;

endpackage

// File: logic/narrow_link_top.sv
`timescale 1ns/10ps

// four-lane narrowing link
// wide words come in over one four-phase handshake and leave as byte pieces
// over another in arrival order
module narrow_link_top (
  input  logic                               clk_i,
  input  logic                               reset_i,

  // wide word input
  input  logic                               in_req_i,
  input  logic [narrow_pkg::WORD_WIDTH-1:0]  in_data_i,
  output logic                               in_ack_o,

  // narrow piece output
  output logic                               out_req_o,
  output logic [narrow_pkg::PIECE_WIDTH-1:0] out_data_o,
  input  logic                               out_ack_i
);

  // one bundle per lane is shared by the dispatcher, that lane and the collector
  lane_if lane_bus [narrow_pkg::NUM_LANES] ();

  word_dispatcher word_dispatcher_inst (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .in_req_i  (in_req_i),
    .in_data_i (in_data_i),
    .in_ack_o  (in_ack_o),
    .lanes     (lane_bus)
  );

  // identical narrowing lanes
  for (genvar i = 0; i < narrow_pkg::NUM_LANES; i++) begin : g_lane
    narrow_lane narrow_lane_inst (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .lane    (lane_bus[i])
    );
  end

  piece_collector piece_collector_inst (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .lanes      (lane_bus),
    .out_req_o  (out_req_o),
    .out_data_o (out_data_o),
    .out_ack_i  (out_ack_i)
  );

endmodule

// File: logic/piece_collector.sv
`timescale 1ns/10ps

// drains the lanes in round-robin order and sends each piece over the
// output four-phase handshake
// it stays on a lane until that lane releases its word, so pieces of one word
// are never split up by pieces of another
module piece_collector (
  input  logic                               clk_i,
  input  logic                               reset_i,
  lane_if.drain                              lanes [narrow_pkg::NUM_LANES],
  output logic                               out_req_o,
  output logic [narrow_pkg::PIECE_WIDTH-1:0] out_data_o,
  input  logic                               out_ack_i
);

  narrow_pkg::hs_state_e                 state_r;
  logic [narrow_pkg::LANE_SEL_WIDTH-1:0] rd_ptr_r;
  logic [narrow_pkg::NUM_LANES-1:0]      valid_vec;
  logic [narrow_pkg::NUM_LANES-1:0]      release_vec;
  logic [narrow_pkg::PIECE_WIDTH-1:0]    piece_arr [narrow_pkg::NUM_LANES];
  logic                                  deque;
  logic                                  start;

  // gather the lane outputs into vectors so the read pointer can index them
  for (genvar i = 0; i < narrow_pkg::NUM_LANES; i++) begin : g_lane
    assign valid_vec[i]   = lanes[i].piece_valid;
    assign release_vec[i] = lanes[i].word_release;
    assign piece_arr[i]   = lanes[i].piece_data;
    // only the selected lane sees the dequeue
    assign lanes[i].piece_deque =
        deque && (rd_ptr_r == narrow_pkg::LANE_SEL_WIDTH'(i));
  end

  // a new request starts only once the sink has dropped its previous ack
  assign start = (state_r == narrow_pkg::hs_idle) && valid_vec[rd_ptr_r] && !out_ack_i;

  // one dequeue per completed handshake happens in the cycle the ack is first seen
  assign deque = (state_r == narrow_pkg::hs_wait_ack_high) && out_ack_i;

  // output handshake
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r   <= narrow_pkg::hs_idle;
      out_req_o <= 1'b0;
      rd_ptr_r  <= '0;
    end else begin
      case (state_r)
        narrow_pkg::hs_idle: begin
          if (start) begin
            out_req_o <= 1'b1;
            state_r   <= narrow_pkg::hs_wait_ack_high;
          end
        end
        narrow_pkg::hs_wait_ack_high: begin
          if (out_ack_i) begin
            out_req_o <= 1'b0;
            state_r   <= narrow_pkg::hs_wait_ack_low;
            // the lane released its word with this dequeue, so its turn is over
            if (release_vec[rd_ptr_r]) begin
              rd_ptr_r <= rd_ptr_r + 1'b1;
            end
          end
        end
        narrow_pkg::hs_wait_ack_low: begin
          if (!out_ack_i) begin
            state_r <= narrow_pkg::hs_idle;
          end
        end
        default: begin
          out_req_o <= 1'b0;
          state_r   <= narrow_pkg::hs_idle;
        end
      endcase
    end
  end

  // the piece is captured as req goes up and holds until the next start,
  // which keeps out_data_o stable for the whole time req is high
  always_ff @(posedge clk_i) begin
    if (start) begin
      out_data_o <= piece_arr[rd_ptr_r];
    end
  end

endmodule

// File: logic/word_dispatcher.sv
`timescale 1ns/10ps

// takes words from the input four-phase handshake and deals them to the lanes
// in strict round-robin order, so the collector can drain in the same order
module word_dispatcher (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              in_req_i,
  input  logic [narrow_pkg::WORD_WIDTH-1:0] in_data_i,
  output logic                              in_ack_o,
  lane_if.feed                              lanes [narrow_pkg::NUM_LANES]
);

  narrow_pkg::in_state_e                   state_r;
  logic [narrow_pkg::LANE_SEL_WIDTH-1:0]   wr_ptr_r;
  logic [narrow_pkg::NUM_LANES-1:0]        lane_free_r;
  logic [narrow_pkg::NUM_LANES-1:0]        release_vec;
  logic                                    load;

  // a word is taken only when it is the lane's turn and that lane is empty
  // otherwise ack stays low and the source waits, which is the back-pressure
  assign load = (state_r == narrow_pkg::in_idle) && in_req_i && lane_free_r[wr_ptr_r];

  // word_valid is combinational so the lane registers the word on the same edge
  // that raises in_ack_o
  for (genvar i = 0; i < narrow_pkg::NUM_LANES; i++) begin : g_lane
    assign lanes[i].word_valid =
        load && (wr_ptr_r == narrow_pkg::LANE_SEL_WIDTH'(i));
    assign lanes[i].word_data  = in_data_i;
    assign release_vec[i]      = lanes[i].word_release;
  end

  // input handshake
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r  <= narrow_pkg::in_idle;
      in_ack_o <= 1'b0;
      wr_ptr_r <= '0;
    end else begin
      case (state_r)
        narrow_pkg::in_idle: begin
          if (load) begin
            in_ack_o <= 1'b1;
            state_r  <= narrow_pkg::in_ack_high;
          end
        end
        narrow_pkg::in_ack_high: begin
          // source has dropped req, so close the cycle and move to the next lane
          if (!in_req_i) begin
            in_ack_o <= 1'b0;
            wr_ptr_r <= wr_ptr_r + 1'b1;
            state_r  <= narrow_pkg::in_idle;
          end
        end
        default: begin
          in_ack_o <= 1'b0;
          state_r  <= narrow_pkg::in_idle;
        end
      endcase
    end
  end

  // one free flag per lane
  // a lane is busy from its load until its last piece has been dequeued
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lane_free_r <= '1;
    end else begin
      for (int i = 0; i < narrow_pkg::NUM_LANES; i++) begin
        if (release_vec[i]) begin
          lane_free_r[i] <= 1'b1;
        end
      end
      // a lane is never loaded and released in the same cycle since load needs it free
      if (load) begin
        lane_free_r[wr_ptr_r] <= 1'b0;
      end
    end
  end

endmodule

// File: verif/narrow_link_asserts.sv
`timescale 1ns/10ps

// handshake rules of both four-phase sides of the link
module narrow_link_asserts (
  input logic                               clk_i,
  input logic                               reset_i,
  input logic                               in_req_i,
  input logic                               in_ack_i,
  input logic                               out_req_i,
  input logic [narrow_pkg::PIECE_WIDTH-1:0] out_data_i,
  input logic                               out_ack_i
);

  // number of handshake rule violations seen so far
  int failures = 0;

  // the sink may sample data at any time while req is up and ack is not yet given
  data_stable_a : assert property (@(posedge clk_i) disable iff (reset_i)
      out_req_i && !out_ack_i |=> $stable(out_data_i))
    else begin
      $error("out_data_o changed while out_req_o was waiting for ack");
      failures++;
    end

  // the input ack only answers a pending request
  in_ack_rise_a : assert property (@(posedge clk_i) disable iff (reset_i)
      $rose(in_ack_i) |-> $past(in_req_i))
    else begin
      $error("in_ack_o rose without in_req_i");
      failures++;
    end

  // a new output request waits until the previous ack is gone
  out_req_rise_a : assert property (@(posedge clk_i) disable iff (reset_i)
      $rose(out_req_i) |-> !$past(out_ack_i))
    else begin
      $error("out_req_o rose while out_ack_i was still high");
      failures++;
    end

endmodule

bind narrow_link_top narrow_link_asserts narrow_link_asserts_inst (
  .clk_i      (clk_i),
  .reset_i    (reset_i),
  .in_req_i   (in_req_i),
  .in_ack_i   (in_ack_o),
  .out_req_i  (out_req_o),
  .out_data_i (out_data_o),
  .out_ack_i  (out_ack_i)
);

// File: verif/narrow_link_checker.sv
`timescale 1ns/10ps

// reference model and scoreboard for the narrowing link
// every word accepted on the input side is split into its expected pieces,
// and every piece offered on the output side is compared with the oldest one
module narrow_link_checker (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  logic                               in_ack_i,
  input  logic [narrow_pkg::WORD_WIDTH-1:0]  in_data_i,
  input  logic                               out_req_i,
  input  logic [narrow_pkg::PIECE_WIDTH-1:0] out_data_i,
  output int                                 words_o,
  output int                                 pieces_o,
  output int                                 errors_o,
  output int                                 pending_o
);

  logic [narrow_pkg::PIECE_WIDTH-1:0] expected_q [$];
  logic in_ack_prev  = 1'b0;
  logic out_req_prev = 1'b0;
  int   words   = 0;
  int   pieces  = 0;
  int   errors  = 0;
  int   pending = 0;

  assign words_o   = words;
  assign pieces_o  = pieces;
  assign errors_o  = errors;
  assign pending_o = pending;

  // piece idx of a word counting from the least significant end
  // the word is widened with zeros, so the last piece gets zero top bits
  function automatic logic [narrow_pkg::PIECE_WIDTH-1:0] split_piece(
      input logic [narrow_pkg::WORD_WIDTH-1:0] word, input int idx);
    logic [narrow_pkg::NUM_PIECES*narrow_pkg::PIECE_WIDTH-1:0] padded;
    padded = {{narrow_pkg::PAD_WIDTH{1'b0}}, word};
    return padded[idx*narrow_pkg::PIECE_WIDTH +: narrow_pkg::PIECE_WIDTH];
  endfunction

  // the falling edge sits half a period away from every DUT and stimulus change
  always @(negedge clk_i) begin
    logic [narrow_pkg::PIECE_WIDTH-1:0] expected;
    if (reset_i) begin
      in_ack_prev  = 1'b0;
      out_req_prev = 1'b0;
    end else begin
      // a rising ack marks one accepted word, and in_data_i is still held then
      if (in_ack_i && !in_ack_prev) begin
        for (int p = 0; p < narrow_pkg::NUM_PIECES; p++) begin
          expected_q.push_back(split_piece(in_data_i, p));
        end
        words++;
      end
      // a rising req marks one piece on the output
      if (out_req_i && !out_req_prev) begin
        if (expected_q.size() == 0) begin
          $display("ERROR at %0t: piece %0d appeared with no word waiting for it",
                   $time, pieces);
          errors++;
        end else begin
          expected = expected_q.pop_front();
          if (out_data_i !== expected) begin
            $display("ERROR at %0t: piece %0d expected 8'h%02h, got 8'h%02h",
                     $time, pieces, expected, out_data_i);
            errors++;
          end
        end
        pieces++;
      end
      in_ack_prev  = in_ack_i;
      out_req_prev = out_req_i;
    end
    pending = expected_q.size();
  end

endmodule

// File: verif/narrow_link_tb.sv
`timescale 1ns/10ps

// testbench for the four-lane narrowing link
// a four-phase source and sink run with random gaps, and the checker compares
module narrow_link_tb;

  localparam int unsigned DRIVE_DELAY  = 1;
  localparam int unsigned WAIT_LIMIT   = 2000;
  localparam int unsigned STREAM_WORDS = 120;
  localparam int unsigned PIECES       = narrow_pkg::NUM_PIECES;

  logic                               clk_i = 1'b0;
  logic                               reset_i;
  logic                               in_req_i;
  logic [narrow_pkg::WORD_WIDTH-1:0]  in_data_i;
  logic                               in_ack_o;
  logic                               out_req_o;
  logic [narrow_pkg::PIECE_WIDTH-1:0] out_data_o;
  logic                               out_ack_i;
  int words_seen;
  int pieces_seen;
  int model_errors;
  int pending;
  int local_errors = 0;
  int tests_run    = 0;

  always #50 clk_i = ~clk_i;

  narrow_link_top narrow_link_top_inst (
    .clk_i (clk_i), .reset_i (reset_i),
    .in_req_i (in_req_i), .in_data_i (in_data_i), .in_ack_o (in_ack_o),
    .out_req_o (out_req_o), .out_data_o (out_data_o), .out_ack_i (out_ack_i)
  );

  narrow_link_checker checker_inst (
    .clk_i (clk_i), .reset_i (reset_i),
    .in_ack_i (in_ack_o), .in_data_i (in_data_i),
    .out_req_i (out_req_o), .out_data_i (out_data_o),
    .words_o (words_seen), .pieces_o (pieces_seen),
    .errors_o (model_errors), .pending_o (pending)
  );

  // handshake rule violations from the bound assertions count as errors too
  function automatic int total_errors();
    return local_errors + model_errors
        + narrow_link_top_inst.narrow_link_asserts_inst.failures;
  endfunction

  // every drive happens a little after the rising edge
  task automatic step();
    @(posedge clk_i);
    #DRIVE_DELAY;
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $finish;
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    $display("test %s finished with %0d errors", name, total_errors() - errors_before);
  endtask

  task automatic offer_word(input logic [narrow_pkg::WORD_WIDTH-1:0] word);
    in_data_i = word;
    in_req_i  = 1'b1;
  endtask

  // rest of the input handshake once req is up
  task automatic finish_word();
    int cycles;
    cycles = 0;
    while (!in_ack_o && cycles < WAIT_LIMIT) begin
      step();
      cycles++;
    end
    if (!in_ack_o) abort_run("The input handshake stalled: in_ack_o never rose.");
    in_req_i = 1'b0;
    cycles = 0;
    while (in_ack_o && cycles < WAIT_LIMIT) begin
      step();
      cycles++;
    end
    if (in_ack_o) abort_run("The input handshake stalled: in_ack_o never fell.");
  endtask

  task automatic send_word(input logic [narrow_pkg::WORD_WIDTH-1:0] word, input int gap);
    repeat (gap) step();
    offer_word(word);
    finish_word();
  endtask

  // the sink answers each request after a random number of cycles
  task automatic receive_pieces(input int count, input int max_delay);
    int cycles;
    for (int n = 0; n < count; n++) begin
      cycles = 0;
      while (!out_req_o && cycles < WAIT_LIMIT) begin
        step();
        cycles++;
      end
      if (!out_req_o) abort_run("The output handshake stalled: out_req_o never rose.");
      repeat ($urandom_range(max_delay, 0)) step();
      out_ack_i = 1'b1;
      cycles = 0;
      while (out_req_o && cycles < WAIT_LIMIT) begin
        step();
        cycles++;
      end
      if (out_req_o) abort_run("The output handshake stalled: out_req_o never fell.");
      out_ack_i = 1'b0;
    end
  endtask

  initial begin
    int errors_before;
    int cycles;
    void'($urandom(32'h76a6b4cd));
    reset_i   = 1'b1;
    in_req_i  = 1'b0;
    in_data_i = '0;
    out_ack_i = 1'b0;

    // both acks and requests stay low through reset and just after it
    errors_before = total_errors();
    for (int i = 0; i < 20; i++) begin
      if (i == 16) reset_i = 1'b0;
      step();
      if (in_ack_o !== 1'b0 || out_req_o !== 1'b0) begin
        $display("ERROR at %0t: handshake outputs not low around reset", $time);
        local_errors++;
      end
    end
    report_test("reset_state", errors_before);

    // directed words with a fast sink let the checker see split and padding
    errors_before = total_errors();
    fork
      begin
        send_word(28'hfffffff, 0);
        send_word(28'haaaaaaa, 0);
        send_word(28'h5555555, 0);
        send_word(28'h8421fed, 0);
      end
      receive_pieces(4 * PIECES, 0);
    join
    report_test("split_padding", errors_before);

    // long random stream with random gaps on both sides
    errors_before = total_errors();
    fork
      repeat (STREAM_WORDS) send_word(narrow_pkg::WORD_WIDTH'($urandom()), $urandom_range(6, 0));
      receive_pieces(STREAM_WORDS * PIECES, 8);
    join
    report_test("lane_ordering", errors_before);

    // no sink at all, so four words fill the lanes and the fifth must wait
    errors_before = total_errors();
    repeat (narrow_pkg::NUM_LANES) send_word(narrow_pkg::WORD_WIDTH'($urandom()), 0);
    offer_word(narrow_pkg::WORD_WIDTH'($urandom()));
    cycles = 0;
    while (!in_ack_o && cycles < 40) begin
      step();
      cycles++;
    end
    if (in_ack_o) begin
      $display("ERROR at %0t: in_ack_o rose while all lanes were full", $time);
      local_errors++;
    end
    fork
      begin
        finish_word();
        repeat (3) send_word(narrow_pkg::WORD_WIDTH'($urandom()), $urandom_range(3, 0));
      end
      receive_pieces(8 * PIECES, 20);
    join
    if (pending != 0) begin
      $display("ERROR at %0t: %0d pieces still expected after back-pressure", $time, pending);
      local_errors++;
    end
    report_test("back_pressure", errors_before);

    // every accepted word must have produced all of its pieces
    errors_before = total_errors();
    repeat (4) step();
    if (pieces_seen != PIECES * words_seen || pending != 0) begin
      $display("ERROR at %0t: %0d pieces checked for %0d words, %0d still expected",
               $time, pieces_seen, words_seen, pending);
      local_errors++;
    end
    report_test("drain_complete", errors_before);

    $display("summary: %0d tests, %0d words, %0d pieces checked, %0d errors",
             tests_run, words_seen, pieces_seen, total_errors());
    if (total_errors() == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
